/* include/kitchen_config.svh */
`ifndef KITCHEN_CONFIG_SVH
`define KITCHEN_CONFIG_SVH

`define GRID_ROWS       8
`define GRID_COLS       13
`define CELL_PIXELS     32

// timer lengths in timer units
`define CHOP_TIME       5
`define COOK_TIME       10
`define BURN_TIME       10
`define TICK_FRAMES     4   // vsync frames per timer unit

// fixed kitchen cells, col then row
`define ONION_COL       0
`define ONION_ROW0      2
`define ONION_ROW1      3
`define BOWL_COL        12
`define BOWL_ROW        6
`define BOARD1_COL      2
`define BOARD2_COL      4
`define BOARD_ROW       7
`define STOVE_COL_FIRST 8   // four stoves side by side
`define STOVE_ROW       0
`define EXT_COL         7
`define EXT_ROW         0
`define SERVE_COL       12
`define SERVE_ROW0      4
`define SERVE_ROW1      5

`endif

/* logic/kitchen_pkg.sv */
`include "kitchen_config.svh"

package kitchen_pkg;

    typedef enum logic [3:0] {
        G_EMPTY,
        G_ONION_WHOLE,
        G_ONION_CHOPPED,
        G_BOWL_EMPTY,
        G_BOWL_FULL,
        G_POT_EMPTY,
        G_POT_RAW,
        G_POT_COOKED,
        G_POT_FIRE,
        G_FIRE,
        G_EXTINGUISHER
    } grid_obj_e;

    typedef enum logic [3:0] {
        P_NOTHING,
        P_CHOPPING,
        P_ONION_WHOLE,
        P_ONION_CHOPPED,
        P_POT_EMPTY,
        P_POT_RAW,
        P_POT_COOKED,
        P_BOWL_EMPTY,
        P_BOWL_FULL,
        P_EXT_OFF,
        P_EXT_ON
    } player_state_e;

    typedef enum logic [1:0] {
        DIR_LEFT,
        DIR_RIGHT,
        DIR_UP,
        DIR_DOWN
    } direction_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COOKING,
        ST_COOKED,
        ST_FIRE
    } stove_state_e;

    typedef grid_obj_e [`GRID_ROWS-1:0][`GRID_COLS-1:0] object_grid_t;   // [row][col]

    // 5 board 1, 4 board 2, 3..0 pots 1..4
    typedef logic [5:0][3:0] time_grid_t;

endpackage

/* logic/stove_if.sv */
interface stove_if;
    import kitchen_pkg::*;

    logic      req;       // stove wants its cell rewritten
    grid_obj_e new_obj;   // value to write, held with req
    logic      ack;       // write done
    grid_obj_e cell_obj;  // what the stove cell holds now

    modport stove (
        output req,
        output new_obj,
        input  ack,
        input  cell_obj
    );

    modport grid (
        input  req,
        input  new_obj,
        output ack,
        output cell_obj
    );

endinterface

/* logic/countdown_timer.sv */
`include "kitchen_config.svh"

module countdown_timer #(
    parameter int GIVEN_TIME = 10
) (
    input  logic       vsync,
    input  logic       reset,
    input  logic       timer_go,
    input  logic       restart,
    output logic [3:0] time_left
);
    localparam int PRESC_W = (`TICK_FRAMES > 1) ? $clog2(`TICK_FRAMES) : 1;

    logic [PRESC_W-1:0] frame_cnt;

    always_ff @(posedge vsync) begin
        if (reset || restart) begin
            frame_cnt <= '0;
            time_left <= 4'(GIVEN_TIME);
        end else if (timer_go && (time_left != 4'd0)) begin   // sticks at zero
            if (frame_cnt == PRESC_W'(`TICK_FRAMES - 1)) begin
                frame_cnt <= '0;
                time_left <= time_left - 4'd1;
            end else begin
                frame_cnt <= frame_cnt + 1'b1;
            end
        end
    end

endmodule

/* logic/facing_cell.sv */
`include "kitchen_config.svh"

module facing_cell (
    input  logic [8:0]                player_loc_x,
    input  logic [8:0]                player_loc_y,
    input  kitchen_pkg::direction_e   player_direction,
    input  kitchen_pkg::object_grid_t object_grid,
    output logic [3:0]                grid_x,
    output logic [2:0]                grid_y,
    output logic [3:0]                x_front,
    output logic [2:0]                y_front,
    output logic                      front_valid,
    output kitchen_pkg::grid_obj_e    object_in_front
);
    import kitchen_pkg::*;

    logic [9:0] px_sum;
    logic [9:0] py_sum;
    logic [4:0] cell_x;
    logic [4:0] cell_y;
    logic [4:0] front_x;
    logic [4:0] front_y;

    // sprite centre, then cell index
    assign px_sum = {1'b0, player_loc_x} + 10'(`CELL_PIXELS / 2);
    assign py_sum = {1'b0, player_loc_y} + 10'(`CELL_PIXELS / 2);
    assign cell_x = 5'(px_sum / `CELL_PIXELS);
    assign cell_y = 5'(py_sum / `CELL_PIXELS);
    assign grid_x = cell_x[3:0];
    assign grid_y = cell_y[2:0];

    always_comb begin
        front_x = cell_x;
        front_y = cell_y;
        case (player_direction)
            DIR_LEFT:  front_x = cell_x - 5'd1;   // wraps to 31 off the edge
            DIR_RIGHT: front_x = cell_x + 5'd1;
            DIR_UP:    front_y = cell_y - 5'd1;
            DIR_DOWN:  front_y = cell_y + 5'd1;
            default:   front_x = cell_x;
        endcase
    end

    assign front_valid = (cell_x < 5'(`GRID_COLS)) && (cell_y < 5'(`GRID_ROWS))
                      && (front_x < 5'(`GRID_COLS)) && (front_y < 5'(`GRID_ROWS));
    assign x_front = front_x[3:0];
    assign y_front = front_y[2:0];
    assign object_in_front = front_valid ? object_grid[y_front][x_front] : G_EMPTY;

endmodule

/* logic/stove_fsm.sv */
`include "kitchen_config.svh"

module stove_fsm #(
    parameter int STOVE_COL = `STOVE_COL_FIRST
) (
    input  logic       vsync,
    input  logic       reset,
    stove_if.stove     sif,
    output logic [3:0] pot_time
);
    import kitchen_pkg::*;

    stove_state_e state;
    logic [3:0]   cook_left;
    logic [3:0]   burn_left;

    if ((STOVE_COL < `STOVE_COL_FIRST) || (STOVE_COL > `STOVE_COL_FIRST + 3)) begin : g_col_check
        $error("stove_fsm: column %0d is not a stove cell", STOVE_COL);
    end

    countdown_timer #(.GIVEN_TIME(`COOK_TIME)) cook_timer (
        .vsync     (vsync),
        .reset     (reset),
        .timer_go  (state == ST_COOKING),
        .restart   (state == ST_IDLE),
        .time_left (cook_left)
    );

    // only runs while a cooked pot sits here
    countdown_timer #(.GIVEN_TIME(`BURN_TIME)) burn_timer (
        .vsync     (vsync),
        .reset     (reset),
        .timer_go  (state == ST_COOKED),
        .restart   (state != ST_COOKED),
        .time_left (burn_left)
    );

    assign pot_time = cook_left;

    // only changes together with the falling req
    assign sif.new_obj = (state == ST_COOKED) ? G_FIRE : G_POT_COOKED;

    always_ff @(posedge vsync) begin
        if (reset) begin
            state   <= ST_IDLE;
            sif.req <= 1'b0;
        end else if (sif.req) begin
            if (sif.ack) begin   // cell written
                sif.req <= 1'b0;
                state   <= (state == ST_COOKING) ? ST_COOKED : ST_FIRE;
            end
        end else begin
            case (state)
                ST_IDLE: begin
                    if (sif.cell_obj == G_POT_RAW) state <= ST_COOKING;
                end
                ST_COOKING: begin
                    if (sif.cell_obj == G_EMPTY) begin
                        state <= ST_IDLE;   // raw pot carried off
                    end else if ((cook_left == 4'd0) && !sif.ack) begin
                        sif.req <= 1'b1;
                    end
                end
                ST_COOKED: begin
                    if (sif.cell_obj != G_POT_COOKED) begin
                        state <= ST_IDLE;
                    end else if ((burn_left == 4'd0) && !sif.ack) begin
                        sif.req <= 1'b1;
                    end
                end
                ST_FIRE: begin
                    if (sif.cell_obj != G_FIRE) state <= ST_IDLE;   // put out
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

/* logic/player_action.sv */
`include "kitchen_config.svh"

module player_action (
    input  logic                       vsync,
    input  logic                       reset,
    input  logic                       chop,
    input  logic                       carry,
    input  logic [1:0]                 clear_space,
    input  logic [3:0]                 grid_x,
    input  logic [2:0]                 grid_y,
    input  kitchen_pkg::direction_e    player_direction,
    input  logic [3:0]                 x_front,
    input  logic [2:0]                 y_front,
    input  logic                       front_valid,
    input  kitchen_pkg::grid_obj_e     object_in_front,
    stove_if.grid                      stove0,
    stove_if.grid                      stove1,
    stove_if.grid                      stove2,
    stove_if.grid                      stove3,
    output kitchen_pkg::player_state_e player_state,
    output kitchen_pkg::object_grid_t  object_grid,
    output logic [1:0][3:0]            board_time
);
    import kitchen_pkg::*;

    localparam int BOARD_COLS [2] = '{`BOARD2_COL, `BOARD1_COL};   // [1] is board 1

    player_state_e p_next;
    logic          p_write;
    grid_obj_e     p_obj;
    logic [1:0]    chop_done;
    logic          grid_busy;
    logic [3:0]    s_req;
    logic [3:0]    s_ack;
    logic [3:0]    pending;
    logic [3:0]    grant;
    grid_obj_e     s_new [4];

    function automatic object_grid_t default_grid();
        object_grid_t g;
        for (int r = 0; r < `GRID_ROWS; r++) begin
            for (int c = 0; c < `GRID_COLS; c++) begin
                g[r][c] = G_EMPTY;
            end
        end
        g[`ONION_ROW0][`ONION_COL] = G_ONION_WHOLE;
        g[`ONION_ROW1][`ONION_COL] = G_ONION_WHOLE;
        g[`BOWL_ROW][`BOWL_COL]    = G_BOWL_EMPTY;
        for (int s = 0; s < 4; s++) begin
            g[`STOVE_ROW][`STOVE_COL_FIRST + s] = G_POT_EMPTY;
        end
        g[`EXT_ROW][`EXT_COL] = G_EXTINGUISHER;
        return g;
    endfunction

    function automatic player_state_e held_of(grid_obj_e obj);
        case (obj)
            G_ONION_WHOLE:   return P_ONION_WHOLE;
            G_ONION_CHOPPED: return P_ONION_CHOPPED;
            G_POT_EMPTY:     return P_POT_EMPTY;
            G_POT_RAW:       return P_POT_RAW;
            G_POT_COOKED:    return P_POT_COOKED;
            G_BOWL_EMPTY:    return P_BOWL_EMPTY;
            G_BOWL_FULL:     return P_BOWL_FULL;
            G_EXTINGUISHER:  return P_EXT_OFF;
            default:         return P_NOTHING;   // fire can't be carried
        endcase
    endfunction

    function automatic grid_obj_e dropped_of(player_state_e ps);
        case (ps)
            P_ONION_WHOLE:   return G_ONION_WHOLE;
            P_ONION_CHOPPED: return G_ONION_CHOPPED;
            P_POT_EMPTY:     return G_POT_EMPTY;
            P_POT_RAW:       return G_POT_RAW;
            P_POT_COOKED:    return G_POT_COOKED;
            P_BOWL_EMPTY:    return G_BOWL_EMPTY;
            P_BOWL_FULL:     return G_BOWL_FULL;
            default:         return G_EMPTY;
        endcase
    endfunction

    function automatic logic is_dispenser(logic [3:0] x, logic [2:0] y);
        return ((x == `ONION_COL) && ((y == `ONION_ROW0) || (y == `ONION_ROW1)))
            || ((x == `BOWL_COL) && (y == `BOWL_ROW));
    endfunction

    // next player state and the single player grid write
    always_comb begin
        p_next  = player_state;
        p_write = 1'b0;
        p_obj   = G_EMPTY;
        case (player_state)
            P_NOTHING: begin
                if (chop) begin
                    p_next = P_CHOPPING;
                end else if (carry && front_valid && (held_of(object_in_front) != P_NOTHING)) begin
                    p_next  = held_of(object_in_front);
                    p_write = !is_dispenser(x_front, y_front);   // dispensers never run out
                end
            end
            P_CHOPPING: begin
                if (!chop) p_next = P_NOTHING;
            end
            P_EXT_OFF: begin
                if (chop) begin
                    p_next = P_EXT_ON;
                end else if (!carry && front_valid && (object_in_front == G_EMPTY)) begin
                    p_next  = P_NOTHING;
                    p_write = 1'b1;
                    p_obj   = G_EXTINGUISHER;
                end
            end
            P_EXT_ON: begin
                if (!chop) begin
                    p_next = P_EXT_OFF;
                end else if (front_valid && (object_in_front != G_EMPTY)) begin
                    p_write = 1'b1;   // spray clears the cell
                end
            end
            default: begin   // holding something
                if (!carry && front_valid) begin
                    if (object_in_front == G_EMPTY) begin
                        p_next  = P_NOTHING;
                        p_write = 1'b1;
                        p_obj   = dropped_of(player_state);
                    end else if (((player_state == P_ONION_CHOPPED)
                                  && (object_in_front == G_POT_EMPTY))
                              || ((player_state == P_POT_EMPTY)
                                  && (object_in_front == G_ONION_CHOPPED))) begin
                        p_next  = P_NOTHING;
                        p_write = 1'b1;
                        p_obj   = G_POT_RAW;
                    end else if ((player_state == P_POT_COOKED)
                              && (object_in_front == G_BOWL_EMPTY)) begin
                        p_next  = P_POT_EMPTY;   // pot stays in hand
                        p_write = 1'b1;
                        p_obj   = G_BOWL_FULL;
                    end
                end
            end
        endcase
    end

    for (genvar b = 0; b < 2; b++) begin : g_board
        logic on_board;
        logic in_place;

        assign on_board = object_grid[`BOARD_ROW][BOARD_COLS[b]] == G_ONION_WHOLE;
        assign in_place = (player_state == P_CHOPPING) && (grid_x == 4'(BOARD_COLS[b]))
                       && (grid_y == 3'(`BOARD_ROW - 1)) && (player_direction == DIR_DOWN);
        assign chop_done[b] = (player_state == P_CHOPPING) && on_board
                           && (board_time[b] == 4'd0);

        countdown_timer #(.GIVEN_TIME(`CHOP_TIME)) board_timer (
            .vsync     (vsync),
            .reset     (reset),
            .timer_go  (in_place && on_board),
            .restart   ((player_state != P_CHOPPING) || chop_done[b]),
            .time_left (board_time[b])
        );
    end

    assign s_req    = {stove3.req, stove2.req, stove1.req, stove0.req};
    assign s_new[0] = stove0.new_obj;
    assign s_new[1] = stove1.new_obj;
    assign s_new[2] = stove2.new_obj;
    assign s_new[3] = stove3.new_obj;
    assign stove0.ack = s_ack[0];
    assign stove1.ack = s_ack[1];
    assign stove2.ack = s_ack[2];
    assign stove3.ack = s_ack[3];
    assign stove0.cell_obj = object_grid[`STOVE_ROW][`STOVE_COL_FIRST];
    assign stove1.cell_obj = object_grid[`STOVE_ROW][`STOVE_COL_FIRST + 1];
    assign stove2.cell_obj = object_grid[`STOVE_ROW][`STOVE_COL_FIRST + 2];
    assign stove3.cell_obj = object_grid[`STOVE_ROW][`STOVE_COL_FIRST + 3];

    // stoves only get a frame with no other grid write
    assign grid_busy = (clear_space != 2'b00) || p_write || (chop_done != 2'b00);
    assign pending   = s_req & ~s_ack;
    assign grant     = grid_busy ? 4'b0000 : (pending & (~pending + 4'd1));   // lowest index

    always_ff @(posedge vsync) begin
        if (reset) begin
            player_state <= P_NOTHING;
            object_grid  <= default_grid();
            s_ack        <= 4'b0000;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (grant[i]) begin
                    s_ack[i] <= 1'b1;
                    object_grid[`STOVE_ROW][`STOVE_COL_FIRST + i] <= s_new[i];
                end else if (!s_req[i]) begin
                    s_ack[i] <= 1'b0;
                end
            end
            for (int b = 0; b < 2; b++) begin
                if (chop_done[b]) object_grid[`BOARD_ROW][BOARD_COLS[b]] <= G_ONION_CHOPPED;
            end
            if (clear_space[0]) object_grid[`SERVE_ROW0][`SERVE_COL] <= G_EMPTY;
            if (clear_space[1]) object_grid[`SERVE_ROW1][`SERVE_COL] <= G_EMPTY;
            if (clear_space == 2'b00) begin   // serving clear blocks the player
                player_state <= p_next;
                if (p_write) object_grid[y_front][x_front] <= p_obj;
            end
        end
    end

endmodule

/* logic/kitchen_top.sv */
`include "kitchen_config.svh"

module kitchen_top (
    input  logic                       vsync,
    input  logic                       reset,
    input  logic                       chop,
    input  logic                       carry,
    input  kitchen_pkg::direction_e    player_direction,
    input  logic [8:0]                 player_loc_x,
    input  logic [8:0]                 player_loc_y,
    input  logic [1:0]                 clear_space,
    output kitchen_pkg::player_state_e player_state,
    output kitchen_pkg::object_grid_t  object_grid,
    output kitchen_pkg::time_grid_t    time_grid
);
    import kitchen_pkg::*;

    logic [3:0]      grid_x;
    logic [2:0]      grid_y;
    logic [3:0]      x_front;
    logic [2:0]      y_front;
    logic            front_valid;
    grid_obj_e       object_in_front;
    logic [1:0][3:0] board_time;
    logic [3:0][3:0] pot_time;   // [i] is stove i, pot i+1

    stove_if stove_bus [4] ();

    facing_cell facing_cell_i (
        .player_loc_x     (player_loc_x),
        .player_loc_y     (player_loc_y),
        .player_direction (player_direction),
        .object_grid      (object_grid),
        .grid_x           (grid_x),
        .grid_y           (grid_y),
        .x_front          (x_front),
        .y_front          (y_front),
        .front_valid      (front_valid),
        .object_in_front  (object_in_front)
    );

    player_action player_action_i (
        .vsync            (vsync),
        .reset            (reset),
        .chop             (chop),
        .carry            (carry),
        .clear_space      (clear_space),
        .grid_x           (grid_x),
        .grid_y           (grid_y),
        .player_direction (player_direction),
        .x_front          (x_front),
        .y_front          (y_front),
        .front_valid      (front_valid),
        .object_in_front  (object_in_front),
        .stove0           (stove_bus[0]),
        .stove1           (stove_bus[1]),
        .stove2           (stove_bus[2]),
        .stove3           (stove_bus[3]),
        .player_state     (player_state),
        .object_grid      (object_grid),
        .board_time       (board_time)
    );

    for (genvar i = 0; i < 4; i++) begin : g_stove
        stove_fsm #(.STOVE_COL(`STOVE_COL_FIRST + i)) stove_fsm_i (
            .vsync    (vsync),
            .reset    (reset),
            .sif      (stove_bus[i]),
            .pot_time (pot_time[i])
        );
    end

    // boards on top, pot 1 down to pot 4 below
    assign time_grid = {board_time, pot_time[0], pot_time[1], pot_time[2], pot_time[3]};

endmodule

/* verif/kitchen_sva.sv */
module kitchen_sva (
    input logic                   vsync,
    input logic                   reset,
    input logic                   req,
    input logic                   ack,
    input kitchen_pkg::grid_obj_e new_obj
);
    int fail_count = 0;

    req_held: assert property (@(posedge vsync) disable iff (reset)
        (req && !ack) |=> req)
    else begin
        $error("stove req dropped before ack");
        fail_count++;
    end

    obj_stable: assert property (@(posedge vsync) disable iff (reset)
        req |=> (!req || $stable(new_obj)))   // may only move as req falls
    else begin
        $error("stove new_obj changed while req high");
        fail_count++;
    end

    ack_after_req: assert property (@(posedge vsync) disable iff (reset)
        ack |-> (req || $past(req)))
    else begin
        $error("stove ack without a recent req");
        fail_count++;
    end

endmodule

/* verif/kitchen_tb.sv */
`include "kitchen_config.svh"

module kitchen_tb;
    import kitchen_pkg::*;

    localparam int CHOP_BOUND  = `CHOP_TIME * `TICK_FRAMES + 8;
    localparam int COOK_BOUND  = `COOK_TIME * `TICK_FRAMES + 8;
    localparam int STOVE_BOUND = (`COOK_TIME + `BURN_TIME) * `TICK_FRAMES + 8;
    // 3 chops, 2 units of early chop, 3 cooks and 1 burn
    localparam int TIMEOUT_FRAMES =
        (3 * `CHOP_TIME + 2 + 3 * `COOK_TIME + `BURN_TIME) * `TICK_FRAMES * 2 + 300;

    logic          vsync;
    logic          reset;
    logic          chop;
    logic          carry;
    direction_e    player_direction;
    logic [8:0]    player_loc_x;
    logic [8:0]    player_loc_y;
    logic [1:0]    clear_space;
    player_state_e player_state;
    object_grid_t  object_grid;
    time_grid_t    time_grid;

    int errors = 0;
    int checks = 0;
    int tests  = 0;
    int frames = 0;

    kitchen_top kitchen_top_i (
        .vsync            (vsync),
        .reset            (reset),
        .chop             (chop),
        .carry            (carry),
        .player_direction (player_direction),
        .player_loc_x     (player_loc_x),
        .player_loc_y     (player_loc_y),
        .clear_space      (clear_space),
        .player_state     (player_state),
        .object_grid      (object_grid),
        .time_grid        (time_grid)
    );

    bind stove_fsm kitchen_sva stove_sva_i (
        .vsync   (vsync),
        .reset   (reset),
        .req     (sif.req),
        .ack     (sif.ack),
        .new_obj (sif.new_obj)
    );

    initial vsync = 1'b0;
    always #5 vsync = ~vsync;

    always @(posedge vsync) begin
        frames++;
        if (frames >= TIMEOUT_FRAMES) begin
            $display("timeout: run stopped after %0d frames without finishing", frames);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_obj(input string name, input grid_obj_e got, input grid_obj_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %s, expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_player(input player_state_e exp);
        checks++;
        if (player_state !== exp) begin
            errors++;
            $display("[ERROR] %0t player_state: got %s, expected %s", $time,
                     player_state.name(), exp.name());
        end
    endtask

    task automatic check_time(input int idx, input logic [3:0] exp);
        checks++;
        if (time_grid[idx] !== exp) begin
            errors++;
            $display("[ERROR] %0t time_grid[%0d]: got %0d, expected %0d", $time, idx,
                     time_grid[idx], exp);
        end
    endtask

    task automatic check_cell(input int col, input int row, input grid_obj_e exp);
        check_obj($sformatf("object_grid[%0d][%0d]", row, col), object_grid[row][col], exp);
    endtask

    // layout straight after reset
    function automatic grid_obj_e reset_obj(input int col, input int row);
        if (col == `ONION_COL && (row == `ONION_ROW0 || row == `ONION_ROW1))
            return G_ONION_WHOLE;
        if (col == `BOWL_COL && row == `BOWL_ROW)
            return G_BOWL_EMPTY;
        if (row == `STOVE_ROW && col >= `STOVE_COL_FIRST && col < `STOVE_COL_FIRST + 4)
            return G_POT_EMPTY;
        if (col == `EXT_COL && row == `EXT_ROW)
            return G_EXTINGUISHER;
        return G_EMPTY;
    endfunction

    task automatic drive(input int col, input int row, input direction_e dir,
                         input logic carry_v, input logic chop_v);
        @(posedge vsync);
        player_loc_x     <= 9'(col * `CELL_PIXELS);
        player_loc_y     <= 9'(row * `CELL_PIXELS);
        player_direction <= dir;
        carry            <= carry_v;
        chop             <= chop_v;
        clear_space      <= 2'b00;
    endtask

    task automatic next_frame();
        @(posedge vsync);
        @(negedge vsync);
    endtask

    task automatic act(input int col, input int row, input direction_e dir,
                       input logic carry_v, input logic chop_v);
        drive(col, row, dir, carry_v, chop_v);
        next_frame();
    endtask

    task automatic wait_cell(input int col, input int row, input grid_obj_e exp,
                             input int bound, output int n);
        n = 0;
        do begin
            next_frame();
            n++;
        end while (object_grid[row][col] !== exp && n < bound);
        checks++;
        if (object_grid[row][col] !== exp) begin
            errors++;
            $display("cell (%0d,%0d) did not become %s within %0d frames", col, row,
                     exp.name(), bound);
        end
    endtask

    task automatic wait_time_zero(input int idx, input int bound);
        int n;
        n = 0;
        do begin
            next_frame();
            n++;
        end while (time_grid[idx] != 4'd0 && n < bound);
        checks++;
        if (time_grid[idx] != 4'd0) begin
            errors++;
            $display("countdown %0d did not reach zero within %0d frames", idx, bound);
        end
    endtask

    // hold chop above a board until its onion turns chopped
    task automatic chop_board(input int col, input int idx);
        int n;
        check_time(idx, 4'(`CHOP_TIME));
        drive(col, `BOARD_ROW - 1, DIR_DOWN, 1'b0, 1'b1);
        wait_cell(col, `BOARD_ROW, G_ONION_CHOPPED, CHOP_BOUND, n);
        checks++;
        if (n <= `CHOP_TIME * `TICK_FRAMES) begin
            errors++;
            $display("board at column %0d was chopped after only %0d frames", col, n);
        end
        act(col, `BOARD_ROW - 1, DIR_DOWN, 1'b0, 1'b0);
        check_player(P_NOTHING);
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        $display("test %-12s %s (%0d errors)", name,
                 (errors == err_before) ? "ok" : "FAILED", errors - err_before);
    endtask

    initial begin
        int start;
        int n;
        int sva_fails;

        reset            = 1'b1;
        chop             = 1'b0;
        carry            = 1'b0;
        player_direction = DIR_DOWN;
        player_loc_x     = '0;
        player_loc_y     = '0;
        clear_space      = 2'b00;
        repeat (2) @(posedge vsync);
        reset <= 1'b0;
        @(negedge vsync);

        start = errors;
        for (int r = 0; r < `GRID_ROWS; r++) begin
            for (int c = 0; c < `GRID_COLS; c++) begin
                check_cell(c, r, reset_obj(c, r));
            end
        end
        check_player(P_NOTHING);
        for (int i = 0; i < 6; i++) begin
            check_time(i, (i >= 4) ? 4'(`CHOP_TIME) : 4'(`COOK_TIME));
        end
        report_test("reset", start);

        start = errors;
        act(1, `ONION_ROW0, DIR_LEFT, 1'b1, 1'b0);
        check_player(P_ONION_WHOLE);
        check_cell(`ONION_COL, `ONION_ROW0, G_ONION_WHOLE);   // dispenser keeps its onion
        act(0, 1, DIR_LEFT, 1'b0, 1'b0);   // off the left edge
        check_player(P_ONION_WHOLE);
        for (int c = 0; c < `GRID_COLS; c++) begin
            check_cell(c, 1, reset_obj(c, 1));   // nothing dropped, not even wrapped around
        end
        act(0, 1, DIR_RIGHT, 1'b0, 1'b0);
        check_player(P_NOTHING);
        check_cell(1, 1, G_ONION_WHOLE);
        report_test("carry", start);

        start = errors;
        act(1, `ONION_ROW1, DIR_LEFT, 1'b1, 1'b0);
        act(`BOARD1_COL, `BOARD_ROW - 1, DIR_DOWN, 1'b0, 1'b0);
        check_cell(`BOARD1_COL, `BOARD_ROW, G_ONION_WHOLE);
        drive(`BOARD1_COL, `BOARD_ROW - 1, DIR_DOWN, 1'b0, 1'b1);
        repeat (2 * `TICK_FRAMES) next_frame();
        check_player(P_CHOPPING);
        act(`BOARD1_COL, `BOARD_ROW - 1, DIR_DOWN, 1'b0, 1'b0);   // let go early
        check_player(P_NOTHING);
        next_frame();
        check_time(5, 4'(`CHOP_TIME));
        check_cell(`BOARD1_COL, `BOARD_ROW, G_ONION_WHOLE);
        chop_board(`BOARD1_COL, 5);
        report_test("chopping", start);

        start = errors;
        act(`BOARD1_COL, `BOARD_ROW - 1, DIR_DOWN, 1'b1, 1'b0);
        check_player(P_ONION_CHOPPED);
        check_cell(`BOARD1_COL, `BOARD_ROW, G_EMPTY);
        act(`STOVE_COL_FIRST, 1, DIR_UP, 1'b0, 1'b0);
        check_cell(`STOVE_COL_FIRST, `STOVE_ROW, G_POT_RAW);
        check_time(3, 4'(`COOK_TIME));
        wait_cell(`STOVE_COL_FIRST, `STOVE_ROW, G_POT_COOKED, STOVE_BOUND, n);
        wait_cell(`STOVE_COL_FIRST, `STOVE_ROW, G_FIRE, STOVE_BOUND, n);
        act(`EXT_COL, 1, DIR_UP, 1'b1, 1'b0);
        check_player(P_EXT_OFF);
        check_cell(`EXT_COL, `EXT_ROW, G_EMPTY);
        act(`STOVE_COL_FIRST, 1, DIR_UP, 1'b1, 1'b1);
        check_player(P_EXT_ON);
        next_frame();   // spray lands one frame later
        check_cell(`STOVE_COL_FIRST, `STOVE_ROW, G_EMPTY);
        act(`STOVE_COL_FIRST, 1, DIR_UP, 1'b1, 1'b0);
        check_player(P_EXT_OFF);
        act(`EXT_COL, 1, DIR_UP, 1'b0, 1'b0);
        check_player(P_NOTHING);
        check_cell(`EXT_COL, `EXT_ROW, G_EXTINGUISHER);
        report_test("cook_fire", start);

        start = errors;
        act(1, `ONION_ROW0, DIR_LEFT, 1'b1, 1'b0);
        act(`BOARD2_COL, `BOARD_ROW - 1, DIR_DOWN, 1'b0, 1'b0);
        chop_board(`BOARD2_COL, 4);
        act(`BOARD2_COL, `BOARD_ROW - 1, DIR_DOWN, 1'b1, 1'b0);
        act(`STOVE_COL_FIRST + 1, 1, DIR_UP, 1'b0, 1'b0);
        check_cell(`STOVE_COL_FIRST + 1, `STOVE_ROW, G_POT_RAW);
        act(`BOWL_COL - 1, `BOWL_ROW, DIR_RIGHT, 1'b1, 1'b0);
        check_player(P_BOWL_EMPTY);
        check_cell(`BOWL_COL, `BOWL_ROW, G_BOWL_EMPTY);
        act(`SERVE_COL - 1, `SERVE_ROW0, DIR_RIGHT, 1'b0, 1'b0);
        check_cell(`SERVE_COL, `SERVE_ROW0, G_BOWL_EMPTY);
        wait_cell(`STOVE_COL_FIRST + 1, `STOVE_ROW, G_POT_COOKED, STOVE_BOUND, n);
        act(`STOVE_COL_FIRST + 1, 1, DIR_UP, 1'b1, 1'b0);
        check_player(P_POT_COOKED);
        act(`SERVE_COL - 1, `SERVE_ROW0, DIR_RIGHT, 1'b0, 1'b0);
        check_cell(`SERVE_COL, `SERVE_ROW0, G_BOWL_FULL);
        check_player(P_POT_EMPTY);
        @(posedge vsync);
        clear_space <= 2'b01;
        next_frame();
        check_cell(`SERVE_COL, `SERVE_ROW0, G_EMPTY);
        report_test("plating", start);

        start = errors;
        act(`STOVE_COL_FIRST + 1, 1, DIR_UP, 1'b0, 1'b0);   // pot back on its stove
        check_cell(`STOVE_COL_FIRST + 1, `STOVE_ROW, G_POT_EMPTY);
        act(1, `ONION_ROW1, DIR_LEFT, 1'b1, 1'b0);
        act(`BOARD1_COL, `BOARD_ROW - 1, DIR_DOWN, 1'b0, 1'b0);
        chop_board(`BOARD1_COL, 5);
        act(`BOARD1_COL, `BOARD_ROW - 1, DIR_DOWN, 1'b1, 1'b0);
        act(`STOVE_COL_FIRST + 1, 1, DIR_UP, 1'b0, 1'b0);
        check_cell(`STOVE_COL_FIRST + 1, `STOVE_ROW, G_POT_RAW);
        act(`EXT_COL, 1, DIR_UP, 1'b0, 1'b0);
        wait_time_zero(2, COOK_BOUND);
        // pick up lands on the frame the stove wants its write
        drive(`EXT_COL, 1, DIR_UP, 1'b1, 1'b0);
        next_frame();
        check_player(P_EXT_OFF);
        check_cell(`EXT_COL, `EXT_ROW, G_EMPTY);
        wait_cell(`STOVE_COL_FIRST + 1, `STOVE_ROW, G_POT_COOKED, STOVE_BOUND, n);
        act(`EXT_COL, 1, DIR_UP, 1'b0, 1'b0);
        check_cell(`EXT_COL, `EXT_ROW, G_EXTINGUISHER);
        report_test("arbitration", start);

        sva_fails = kitchen_top_i.g_stove[0].stove_fsm_i.stove_sva_i.fail_count
                  + kitchen_top_i.g_stove[1].stove_fsm_i.stove_sva_i.fail_count
                  + kitchen_top_i.g_stove[2].stove_fsm_i.stove_sva_i.fail_count
                  + kitchen_top_i.g_stove[3].stove_fsm_i.stove_sva_i.fail_count;
        if (sva_fails != 0) begin
            $display("stove handshake assertions failed %0d times", sva_fails);
        end
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors + sva_fails);
        if (errors == 0 && sva_fails == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+include
logic/kitchen_pkg.sv
logic/stove_if.sv
logic/countdown_timer.sv
logic/facing_cell.sv
logic/stove_fsm.sv
logic/player_action.sv
logic/kitchen_top.sv
verif/kitchen_sva.sv
verif/kitchen_tb.sv

/* Bender.yml */
package:
  name: kitchen

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/kitchen_pkg.sv
      - logic/stove_if.sv
      - logic/countdown_timer.sv
      - logic/facing_cell.sv
      - logic/stove_fsm.sv
      - logic/player_action.sv
      - logic/kitchen_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/kitchen_sva.sv
      - verif/kitchen_tb.sv
